/* filelist.f */
verilog/mips_pkg.sv
verilog/bypass_if.sv
verilog/stage_reg.sv
verilog/mips_fetch.sv
verilog/mips_decode.sv
verilog/mips_execute.sv
verilog/mips_data_mem.sv
verilog/mips_core.sv
verification/mips_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the MIPS core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module mips_core_tb -Mdir obj_dir -o mips_core_sim \
	-f filelist.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/mips_core_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi
exit 0

/* verification/mips_core_tb.sv */
`timescale 1ns/100ps

module mips_core_tb
	import mips_pkg::*;
();

	localparam int ROM_AW = 6;
	localparam int ROM_WORDS = 2**ROM_AW;
	localparam int CASE_LINES = 64;
	localparam int CASE_WORDS = 3 * CASE_LINES;   // Tag and two fields per line
	localparam int MAX_WB = 32;
	localparam int DRAIN_CYCLES = 20;

	localparam logic [DATA_W-1:0] TAG_NONE   = 32'h0;
	localparam logic [DATA_W-1:0] TAG_PROG   = 32'h1;
	localparam logic [DATA_W-1:0] TAG_WB     = 32'h2;
	localparam logic [DATA_W-1:0] TAG_BUDGET = 32'h3;

	logic                  clk;
	logic                  reset;
	logic [DATA_W-1:0]     imem_addr;
	logic [DATA_W-1:0]     imem_data;
	logic                  wb_valid;
	logic [REG_ADDR_W-1:0] wb_reg;
	logic [DATA_W-1:0]     wb_data;

	logic [DATA_W-1:0]     cases [CASE_WORDS];
	logic [DATA_W-1:0]     rom [ROM_WORDS];
	logic [REG_ADDR_W-1:0] exp_reg [MAX_WB];
	logic [DATA_W-1:0]     exp_data [MAX_WB];
	int                    exp_count = 0;
	int                    wb_seen = 0;          // Writebacks checked so far
	int                    cycle_budget = 0;

	mips_core DUT (
		.clk(clk),
		.reset(reset),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.wb_valid(wb_valid),
		.wb_reg(wb_reg),
		.wb_data(wb_data)
	);

	always #4 clk = ~clk;

	// --------------------
	// Reporting and checks
	// --------------------
	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_reg_index(input string name, input logic [REG_ADDR_W-1:0] actual,
		input logic [REG_ADDR_W-1:0] expected);
		if (actual !== expected) begin
			stop_on_error($sformatf("[ERROR] %0t %s: got %0d, expected %0d",
				$time, name, actual, expected));
		end
	endtask

	task automatic check_data(input string name, input logic [DATA_W-1:0] actual,
		input logic [DATA_W-1:0] expected);
		if (actual !== expected) begin
			stop_on_error($sformatf("[ERROR] %0t %s: got %h, expected %h",
				$time, name, actual, expected));
		end
	endtask

	// --------------------
	// Instruction ROM
	// --------------------
	// Anything outside the loaded window reads as a nop
	function automatic logic [DATA_W-1:0] rom_read(input logic [DATA_W-1:0] addr);
		logic [DATA_W-1:0] offset;
		offset = addr - RESET_PC;
		if (offset[DATA_W-1:ROM_AW+2] != '0) begin
			return '0;
		end
		return rom[offset[ROM_AW+1:2]];
	endfunction

	always @(posedge clk) begin
		imem_data <= rom_read(imem_addr);     // One-cycle synchronous read
	end

	task automatic load_cases();
		int                i;
		logic [DATA_W-1:0] tag;
		logic [DATA_W-1:0] field_a;
		logic [DATA_W-1:0] field_b;
		logic [DATA_W-1:0] offset;
		for (i = 0; i < CASE_WORDS; i++) begin
			cases[i] = '0;
		end
		for (i = 0; i < ROM_WORDS; i++) begin
			rom[i] = '0;
		end
		$readmemh("verification/program_cases.txt", cases);
		for (i = 0; i < CASE_WORDS; i += 3) begin
			tag     = cases[i];
			field_a = cases[i+1];
			field_b = cases[i+2];
			offset  = field_a - RESET_PC;
			case (tag)
				TAG_NONE: ;                          // Unused tail of the array
				TAG_PROG: begin
					if (offset[DATA_W-1:ROM_AW+2] != '0 || offset[1:0] != 2'b00) begin
						stop_on_error($sformatf("program address %h does not fit the ROM model",
							field_a));
					end else begin
						rom[offset[ROM_AW+1:2]] = field_b;
					end
				end
				TAG_WB: begin
					if (exp_count >= MAX_WB) begin
						stop_on_error("case file lists more writebacks than the checker holds");
					end else begin
						exp_reg[exp_count]  = field_a[REG_ADDR_W-1:0];
						exp_data[exp_count] = field_b;
						exp_count++;
					end
				end
				TAG_BUDGET: cycle_budget = int'(field_a);
				default: stop_on_error($sformatf("unknown tag %h in case line %0d", tag, i / 3));
			endcase
		end
		if (exp_count == 0 || cycle_budget == 0) begin
			stop_on_error("case file gave no expected writebacks or no cycle budget");
		end
	endtask

	// --------------------
	// Writeback checker
	// --------------------
	// Sampled mid-cycle, away from the edge that updates the trace
	always @(negedge clk) begin
		if (!reset && wb_valid) begin
			if (wb_seen >= exp_count) begin
				stop_on_error($sformatf("unexpected extra writeback to register %0d at %0t",
					wb_reg, $time));
			end else begin
				check_reg_index("wb_reg", wb_reg, exp_reg[wb_seen]);
				check_data("wb_data", wb_data, exp_data[wb_seen]);
				wb_seen = wb_seen + 1;
			end
		end
	end

	initial begin
		int cycles;
		clk = 1'b0;
		reset = 1'b1;
		imem_data = '0;
		load_cases();
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		cycles = 0;
		while (wb_seen < exp_count && cycles < cycle_budget) begin
			@(posedge clk);
			cycles++;
		end

		if (wb_seen == exp_count) begin
			repeat (DRAIN_CYCLES) @(posedge clk);   // Self-jump must stay quiet
			$display("Result: PASSED");
			$finish;
		end else begin
			stop_on_error($sformatf("timeout, only %0d of %0d expected writebacks arrived in %0d cycles",
				wb_seen, exp_count, cycle_budget));
		end
	end

endmodule

/* verification/program_cases.txt */
// Each line holds a tag and two hex fields
// Tag 1 is a program word after its address, tag 2 an expected writeback register and value
// Tag 3 gives the cycle budget in the first field
1 00400000 20080005   // addi $8, $0, 5
1 00400004 2009000e   // addi $9, $0, 14
1 00400008 01095020   // add $10, $8, $9
1 0040000c 01485822   // sub $11, $10, $8
1 00400010 014b6024   // and $12, $10, $11
1 00400014 014b6825   // or $13, $10, $11
1 00400018 0109702a   // slt $14, $8, $9
1 0040001c 20000007   // addi $0, $0, 7
1 00400020 00087822   // sub $15, $0, $8
1 00400024 01e8802a   // slt $16, $15, $8
1 00400028 ac0a0010   // sw $10, 16($0)
1 0040002c 8c110010   // lw $17, 16($0)
1 00400030 02289020   // add $18, $17, $8
1 00400034 11090001   // beq $8, $9, +1
1 00400038 20130064   // addi $19, $0, 100
1 0040003c 11690001   // beq $11, $9, +1
1 00400040 201400c8   // addi $20, $0, 200
1 00400044 08100013   // j 0x0040004c
1 00400048 2015012c   // addi $21, $0, 300
1 0040004c 201601f4   // addi $22, $0, 500
1 00400050 08100014   // j 0x00400050
// Retired writes in program order
2 00000008 00000005
2 00000009 0000000e
2 0000000a 00000013
2 0000000b 0000000e
2 0000000c 00000002
2 0000000d 0000001f
2 0000000e 00000001
2 0000000f fffffffb
2 00000010 00000001
2 00000011 00000013
2 00000012 00000018
2 00000013 00000064
2 00000016 000001f4
3 000000c8 00000000

/* verilog/bypass_if.sv */
`timescale 1ns/100ps

interface bypass_if
	import mips_pkg::*;
();

	// Result sitting in the memory stage, loads excluded
	logic                  mem_write_en;
	logic [REG_ADDR_W-1:0] mem_dest;
	logic [DATA_W-1:0]     mem_value;

	// Result being written back this cycle
	logic                  wb_write_en;
	logic [REG_ADDR_W-1:0] wb_dest;
	logic [DATA_W-1:0]     wb_value;

	modport source (
		output mem_write_en, mem_dest, mem_value,
		output wb_write_en, wb_dest, wb_value
	);

	modport sink (
		input mem_write_en, mem_dest, mem_value,
		input wb_write_en, wb_dest, wb_value
	);

endinterface

/* verilog/mips_core.sv */
`timescale 1ns/100ps

module mips_core
	import mips_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	output logic [DATA_W-1:0]     imem_addr,
	input  logic [DATA_W-1:0]     imem_data,    // Word at last cycle's imem_addr
	output logic                  wb_valid,
	output logic [REG_ADDR_W-1:0] wb_reg,
	output logic [DATA_W-1:0]     wb_data
);

	logic              stall;
	logic              redirect;
	logic [DATA_W-1:0] redirect_addr;
	logic              instr_valid;
	logic [DATA_W-1:0] instr_pc;

	ex_payload_t  dx_d;
	ex_payload_t  dx_q;
	mem_payload_t xm_d;
	mem_payload_t xm_q;
	wb_payload_t  mw_d;
	wb_payload_t  mw_q;

	bypass_if bypass ();

	// --------------------
	// Stages
	// --------------------
	mips_fetch mips_fetch (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.redirect(redirect),
		.redirect_addr(redirect_addr),
		.imem_addr(imem_addr),
		.instr_valid(instr_valid),
		.instr_pc(instr_pc)
	);

	mips_decode mips_decode (
		.clk(clk),
		.reset(reset),
		.instr(imem_data),
		.instr_valid(instr_valid),
		.instr_pc(instr_pc),
		.wb_write_en(mw_q.reg_write),
		.wb_dest(mw_q.dest),
		.wb_value(mw_q.value),
		.x_mem_read(dx_q.mem_read),
		.x_dest(dx_q.dest),
		.ex_out(dx_d),
		.stall(stall),
		.redirect(redirect),
		.redirect_addr(redirect_addr)
	);

	// Bubble into execute while decode waits on a load
	stage_reg #(.payload_t(ex_payload_t)) dx_reg (
		.clk(clk), .reset(reset), .flush(stall), .d(dx_d), .q(dx_q)
	);

	mips_execute mips_execute (
		.ex_in(dx_q),
		.bypass(bypass),
		.mem_out(xm_d)
	);

	stage_reg #(.payload_t(mem_payload_t)) xm_reg (
		.clk(clk), .reset(reset), .flush(1'b0), .d(xm_d), .q(xm_q)
	);

	mips_data_mem mips_data_mem (
		.clk(clk),
		.mem_in(xm_q),
		.wb_out(mw_d)
	);

	stage_reg #(.payload_t(wb_payload_t)) mw_reg (
		.clk(clk), .reset(reset), .flush(1'b0), .d(mw_d), .q(mw_q)
	);

	// Bypass sources, load data in M is never forwarded
	assign bypass.mem_write_en = xm_q.reg_write && !xm_q.mem_read;
	assign bypass.mem_dest     = xm_q.dest;
	assign bypass.mem_value    = xm_q.alu_result;
	assign bypass.wb_write_en  = mw_q.reg_write;
	assign bypass.wb_dest      = mw_q.dest;
	assign bypass.wb_value     = mw_q.value;

	// Retire trace
	assign wb_valid = mw_q.reg_write;
	assign wb_reg   = mw_q.dest;
	assign wb_data  = mw_q.value;

endmodule

/* verilog/mips_data_mem.sv */
`timescale 1ns/100ps

module mips_data_mem
	import mips_pkg::*;
(
	input  logic         clk,
	input  mem_payload_t mem_in,
	output wb_payload_t  wb_out
);

	logic [DATA_W-1:0]      mem [DATA_MEM_DEPTH];
	logic [DATA_MEM_AW-1:0] word_index;

	// Byte address to word index, upper bits ignored
	assign word_index = mem_in.alu_result[DATA_MEM_AW+1:2];

	always_ff @(posedge clk) begin
		if (mem_in.mem_write) begin
			mem[word_index] <= mem_in.store_data;
		end
	end

	always_comb begin
		wb_out.reg_write = mem_in.reg_write;
		wb_out.dest      = mem_in.dest;
		wb_out.value     = mem_in.mem_read ? mem[word_index] : mem_in.alu_result;
	end

	// Only whole words are addressed
	a_word_aligned: assert property (@(posedge clk)
		(mem_in.mem_read || mem_in.mem_write) |-> (mem_in.alu_result[1:0] == 2'b00));

endmodule

/* verilog/mips_decode.sv */
`timescale 1ns/100ps

module mips_decode
	import mips_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic [DATA_W-1:0]     instr,
	input  logic                  instr_valid,
	input  logic [DATA_W-1:0]     instr_pc,
	input  logic                  wb_write_en,
	input  logic [REG_ADDR_W-1:0] wb_dest,
	input  logic [DATA_W-1:0]     wb_value,
	input  logic                  x_mem_read,
	input  logic [REG_ADDR_W-1:0] x_dest,
	output ex_payload_t           ex_out,
	output logic                  stall,
	output logic                  redirect,
	output logic [DATA_W-1:0]     redirect_addr
);

	logic [5:0]            opcode;
	logic [5:0]            funct;
	logic [REG_ADDR_W-1:0] rs;
	logic [REG_ADDR_W-1:0] rt;
	logic [REG_ADDR_W-1:0] rd;
	logic [DATA_W-1:0]     imm_ext;
	logic [DATA_W-1:0]     rs_value;
	logic [DATA_W-1:0]     rt_value;
	logic [DATA_W-1:0]     pc_plus4;
	logic [DATA_W-1:0]     branch_addr;
	logic [DATA_W-1:0]     jump_addr;
	logic [DATA_W-1:0]     regs [2**REG_ADDR_W];

	alu_op_t               alu_op;
	logic                  alu_src;
	logic                  reg_write;
	logic                  mem_read;
	logic                  mem_write;
	logic                  mem_to_reg;
	logic [REG_ADDR_W-1:0] dest;
	logic                  uses_rs;
	logic                  uses_rt;
	logic                  is_beq;
	logic                  is_jump;
	logic                  load_hazard;

	assign opcode  = instr[31:26];
	assign rs      = instr[25:21];
	assign rt      = instr[20:16];
	assign rd      = instr[15:11];
	assign funct   = instr[5:0];
	assign imm_ext = {{16{instr[15]}}, instr[15:0]};

	// --------------------
	// Control decode
	// --------------------
	always_comb begin
		alu_op     = ALU_ADD;
		alu_src    = 1'b0;
		reg_write  = 1'b0;
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		mem_to_reg = 1'b0;
		dest       = rt;                          // I-type writes rt
		uses_rs    = 1'b0;
		uses_rt    = 1'b0;
		is_beq     = 1'b0;
		is_jump    = 1'b0;
		if (instr_valid) begin
			case (opcode)
				OP_RTYPE: begin
					dest      = rd;
					uses_rs   = 1'b1;
					uses_rt   = 1'b1;
					reg_write = 1'b1;
					case (funct)
						FN_ADD: alu_op = ALU_ADD;
						FN_SUB: alu_op = ALU_SUB;
						FN_AND: alu_op = ALU_AND;
						FN_OR: alu_op = ALU_OR;
						FN_SLT: alu_op = ALU_SLT;
						default: reg_write = 1'b0;   // Unsupported funct, nop
					endcase
				end
				OP_ADDI: begin
					uses_rs   = 1'b1;
					alu_src   = 1'b1;
					reg_write = 1'b1;
				end
				OP_LW: begin
					uses_rs    = 1'b1;
					alu_src    = 1'b1;
					reg_write  = 1'b1;
					mem_read   = 1'b1;
					mem_to_reg = 1'b1;
				end
				OP_SW: begin
					uses_rs   = 1'b1;
					uses_rt   = 1'b1;           // Store data
					alu_src   = 1'b1;
					mem_write = 1'b1;
				end
				OP_BEQ: begin
					uses_rs = 1'b1;
					uses_rt = 1'b1;
					is_beq  = 1'b1;
				end
				OP_J: is_jump = 1'b1;
				default: ;
			endcase
		end
	end

	// --------------------
	// Register file
	// --------------------
	always_ff @(posedge clk) begin
		if (wb_write_en) begin
			regs[wb_dest] <= wb_value;
		end
	end

	function automatic logic [DATA_W-1:0] read_reg(input logic [REG_ADDR_W-1:0] idx);
		if (idx == '0) begin
			return '0;
		end
		if (wb_write_en && wb_dest == idx) begin
			return wb_value;                      // Same-cycle pass-through
		end
		return regs[idx];
	endfunction

	assign rs_value = read_reg(rs);
	assign rt_value = read_reg(rt);

	// Hazard and redirect
	// beq compares register-file values only, nothing is forwarded here
	assign load_hazard = x_mem_read && (x_dest != '0)
		&& ((uses_rs && x_dest == rs) || (uses_rt && x_dest == rt));
	assign stall = load_hazard;

	assign pc_plus4      = instr_pc + 32'd4;
	assign branch_addr   = pc_plus4 + {imm_ext[DATA_W-3:0], 2'b00};
	assign jump_addr     = {pc_plus4[31:28], instr[25:0], 2'b00};
	// A branch waiting on a load holds off, a jump reads no register
	assign redirect      = is_jump || (is_beq && !load_hazard && rs_value == rt_value);
	assign redirect_addr = is_jump ? jump_addr : branch_addr;

	always_comb begin
		ex_out            = '0;
		ex_out.alu_op     = alu_op;
		ex_out.alu_src    = alu_src;
		ex_out.reg_write  = reg_write && (dest != '0);   // $zero never written
		ex_out.mem_read   = mem_read;
		ex_out.mem_write  = mem_write;
		ex_out.mem_to_reg = mem_to_reg;
		ex_out.dest       = dest;
		ex_out.rs         = rs;
		ex_out.rt         = rt;
		ex_out.rs_value   = rs_value;
		ex_out.rt_value   = rt_value;
		ex_out.imm        = imm_ext;
	end

	// Writes to $zero are dropped here, three stages before they would retire
	a_no_zero_write: assert property (@(posedge clk) disable iff (reset)
		!(wb_write_en && wb_dest == '0));

	a_no_redirect_on_stall: assert property (@(posedge clk) disable iff (reset)
		stall |-> !redirect);

endmodule

/* verilog/mips_execute.sv */
`timescale 1ns/100ps

module mips_execute
	import mips_pkg::*;
(
	input  ex_payload_t   ex_in,
	bypass_if.sink        bypass,
	output mem_payload_t  mem_out
);

	logic [DATA_W-1:0] src_a;
	logic [DATA_W-1:0] rt_fwd;
	logic [DATA_W-1:0] src_b;
	logic [DATA_W-1:0] alu_result;

	// --------------------
	// Forwarding
	// --------------------
	// Memory stage is younger, so it wins over writeback
	function automatic logic [DATA_W-1:0] forward(
		input logic [REG_ADDR_W-1:0] idx,
		input logic [DATA_W-1:0]     reg_value
	);
		if (idx == '0) begin
			return reg_value;
		end
		if (bypass.mem_write_en && bypass.mem_dest == idx) begin
			return bypass.mem_value;
		end
		if (bypass.wb_write_en && bypass.wb_dest == idx) begin
			return bypass.wb_value;
		end
		return reg_value;
	endfunction

	assign src_a  = forward(ex_in.rs, ex_in.rs_value);
	assign rt_fwd = forward(ex_in.rt, ex_in.rt_value);
	assign src_b  = ex_in.alu_src ? ex_in.imm : rt_fwd;

	// --------------------
	// ALU
	// --------------------
	always_comb begin
		case (ex_in.alu_op)
			ALU_ADD: alu_result = src_a + src_b;
			ALU_SUB: alu_result = src_a - src_b;
			ALU_AND: alu_result = src_a & src_b;
			ALU_OR: alu_result = src_a | src_b;
			ALU_SLT: alu_result = {{(DATA_W-1){1'b0}}, $signed(src_a) < $signed(src_b)};
			default: alu_result = '0;
		endcase
	end

	always_comb begin
		mem_out.reg_write  = ex_in.reg_write;
		mem_out.mem_read   = ex_in.mem_to_reg;   // Load data replaces ALU result
		mem_out.mem_write  = ex_in.mem_write;
		mem_out.dest       = ex_in.dest;
		mem_out.alu_result = alu_result;         // Also the load/store address
		mem_out.store_data = rt_fwd;
	end

endmodule

/* verilog/mips_fetch.sv */
`timescale 1ns/100ps

module mips_fetch
	import mips_pkg::*;
(
	input  logic              clk,
	input  logic              reset,
	input  logic              stall,
	input  logic              redirect,
	input  logic [DATA_W-1:0] redirect_addr,
	output logic [DATA_W-1:0] imem_addr,
	output logic              instr_valid,   // Word arriving in decode is live
	output logic [DATA_W-1:0] instr_pc       // Address of the word in decode
);

	logic [DATA_W-1:0] pc;
	logic [DATA_W-1:0] pc_next;

	// Re-read the held word while decode is stalled
	assign imem_addr = stall ? instr_pc : pc;

	always_comb begin
		if (stall) begin
			pc_next = pc;
		end else if (redirect) begin
			pc_next = redirect_addr;
		end else begin
			pc_next = pc + 32'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc          <= RESET_PC;
			instr_pc    <= RESET_PC;
			instr_valid <= 1'b0;               // No word fetched yet
		end else begin
			pc          <= pc_next;
			instr_pc    <= imem_addr;
			instr_valid <= !redirect;          // Kill the fall-through word
		end
	end

endmodule

/* verilog/mips_pkg.sv */
package mips_pkg;

	// --------------------
	// Widths and sizes
	// --------------------
	localparam int DATA_W = 32;
	localparam int REG_ADDR_W = 5;
	localparam int DATA_MEM_DEPTH = 256;                    // Words
	localparam int DATA_MEM_AW = $clog2(DATA_MEM_DEPTH);

	localparam logic [DATA_W-1:0] RESET_PC = 32'h0040_0000;

	// --------------------
	// Instruction encodings
	// --------------------
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_J     = 6'h02;

	// Funct field of R-type
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} alu_op_t;

	// --------------------
	// Stage payloads
	// --------------------
	typedef struct packed {
		alu_op_t               alu_op;
		logic                  alu_src;      // Immediate as operand B
		logic                  reg_write;
		logic                  mem_read;
		logic                  mem_write;
		logic                  mem_to_reg;
		logic [REG_ADDR_W-1:0] dest;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [DATA_W-1:0]     rs_value;
		logic [DATA_W-1:0]     rt_value;
		logic [DATA_W-1:0]     imm;          // Already sign extended
	} ex_payload_t;

	typedef struct packed {
		logic                  reg_write;
		logic                  mem_read;
		logic                  mem_write;
		logic [REG_ADDR_W-1:0] dest;
		logic [DATA_W-1:0]     alu_result;
		logic [DATA_W-1:0]     store_data;
	} mem_payload_t;

	typedef struct packed {
		logic                  reg_write;
		logic [REG_ADDR_W-1:0] dest;
		logic [DATA_W-1:0]     value;
	} wb_payload_t;

endpackage

/* verilog/stage_reg.sv */
`timescale 1ns/100ps

module stage_reg
	import mips_pkg::*;
#(
	parameter type payload_t = logic [DATA_W-1:0]
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     flush,       // Turns this slot into a bubble
	input  payload_t d,
	output payload_t q
);

	// All enables live in the payload, so zero is a harmless bubble
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			q <= '0;
		end else begin
			q <= d;
		end
	end

endmodule
